//--- project.f
exec_pkg.sv
alu.sv
meta_unit.sv
cfu.sv
execute.sv
exec_core.sv
exec_core_props.sv
tb_exec_core.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - exec_pkg.sv
  - alu.sv
  - meta_unit.sv
  - cfu.sv
  - execute.sv
  - exec_core.sv
  - target: test
    files:
      - exec_core_props.sv
      - tb_exec_core.sv

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

  logic        clk;
  logic        rst_n;
  logic        step_valid;
  logic [6:0]  opc;
  logic [31:0] opnd0_r;
  logic [31:0] opnd1_r;
  logic [31:0] opnd2_r;
  logic [3:0]  instr_len;
  logic        ecx_is_zero;
  logic        done;
  logic [31:0] opnd0_w;
  logic [31:0] opnd1_w;
  logic [31:0] eflags;
  logic [31:0] eip;
  int          err_count;
  int          test_count;
  logic [31:0] lfsr_state;
  logic [6:0]  rand_ops [6] = '{exec_pkg::CMD_ADD, exec_pkg::CMD_SUB, exec_pkg::CMD_AND,
                                exec_pkg::CMD_XOR, exec_pkg::CMD_SHL, exec_pkg::CMD_ROR};

  exec_core uut (.*);

  bind exec_core exec_core_props props_i (
    .clk(clk), .rst_n(rst_n), .step_valid(step_valid), .opc(opc), .opnd0_r(opnd0_r),
    .opnd1_r(opnd1_r), .instr_len(instr_len), .done(done), .opnd0_w(opnd0_w),
    .eflags(eflags), .eip(eip)
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $error("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Drive one step on the falling edge and wait for its done
  task automatic run_step(input logic [6:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic [3:0] len, input logic ecx_zero);
    int waited;
    opc = op;
    opnd0_r = a;
    opnd1_r = b;
    opnd2_r = c;
    instr_len = len;
    ecx_is_zero = ecx_zero;
    step_valid = 1'b1;
    waited = 0;
    @(negedge clk);
    step_valid = 1'b0;
    while (!done && waited < 10) begin
      waited++;
      @(negedge clk);
    end
    if (!done) begin
      $display("Timeout: no done within 10 cycles of a step, opcode %0d", op);
      $display("Done: errors found");
      $finish;
    end
  endtask

  // Expected EIP from a flag condition chosen by the caller
  task automatic check_branch(input logic [6:0] op, input logic ecx_zero, input logic taken,
                              input string what);
    logic [31:0] start_eip;
    logic [31:0] target;
    logic [31:0] ret;
    logic [3:0]  len;
    start_eip = eip;
    target = take_bits(32);
    ret = take_bits(32);
    len = take_bits(4);
    run_step(op, target, 32'h0000_8000, ret, len, ecx_zero);
    check_value(eip, (op == exec_pkg::CMD_RET) ? ret :
                     taken ? target : start_eip + len, what);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("%s: %s", name, (err_count == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] saved;
    logic [7:0]  ah;
    int          errs;
    int          i;
    clk = 1'b0;
    rst_n = 1'b0;
    step_valid = 1'b0;
    opc = exec_pkg::CMD_NOP;
    opnd0_r = '0;
    opnd1_r = '0;
    opnd2_r = '0;
    instr_len = '0;
    ecx_is_zero = 1'b0;
    err_count = 0;
    test_count = 0;
    lfsr_state = 32'hf66b;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    errs = err_count;
    check_value(done, 0, "done after reset");
    check_value(eflags, exec_pkg::EFLAGS_RESET, "eflags after reset");
    check_value(eip, 0, "eip after reset");
    end_test("reset", errs);

    // Props module checks result, flags and EIP
    errs = err_count;
    for (i = 0; i < 40; i++) begin
      a = take_bits(32);
      b = take_bits(32);
      run_step(rand_ops[take_bits(3) % 6], a, b, 32'd0, take_bits(4), 1'b0);
    end
    end_test("random alu", errs);

    errs = err_count;
    run_step(exec_pkg::CMD_CMP, 32'd17, 32'd40, 32'd0, 4'd2, 1'b0);
    check_value(opnd0_w, 32'd17, "CMP opnd0_w");
    check_value(eflags[exec_pkg::EFLAGS_CF], 1, "CMP borrow");
    check_value(eflags[exec_pkg::EFLAGS_ZF], 0, "CMP ZF");
    run_step(exec_pkg::CMD_TEST, 32'hf0f0_0000, 32'h0f0f_ffff, 32'd0, 4'd2, 1'b0);
    check_value(opnd0_w, 32'hf0f0_0000, "TEST opnd0_w");
    check_value(eflags[exec_pkg::EFLAGS_ZF], 1, "TEST ZF");
    check_value(eflags[exec_pkg::EFLAGS_CF], 0, "TEST CF");
    saved = eflags;
    run_step(exec_pkg::CMD_PUSH, 32'h1234, 32'h0000_1000, 32'd4, 4'd1, 1'b0);
    check_value(opnd1_w, 32'h0000_0ffc, "PUSH opnd1_w");
    check_value(eflags, saved, "PUSH eflags");
    end_test("compare and adjust", errs);

    errs = err_count;
    saved = eflags;
    run_step(exec_pkg::CMD_MOVSX, 32'd0, 32'h5555_559c, 32'd0, 4'd3, 1'b0);
    check_value(opnd0_w, 32'hffff_ff9c, "MOVSX result");
    run_step(exec_pkg::CMD_MOVZX, 32'd0, 32'h5555_559c, 32'd0, 4'd3, 1'b0);
    check_value(opnd0_w, 32'h0000_009c, "MOVZX result");
    a = take_bits(32);
    b = take_bits(32);
    run_step(exec_pkg::CMD_XCHG, a, b, 32'd0, 4'd1, 1'b0);
    check_value(opnd0_w, b, "XCHG opnd0_w");
    check_value(opnd1_w, a, "XCHG opnd1_w");
    check_value(eflags, saved, "eflags after moves");
    end_test("moves", errs);

    errs = err_count;
    run_step(exec_pkg::CMD_STC, 32'd0, 32'd0, 32'd0, 4'd1, 1'b0);
    check_value(eflags[exec_pkg::EFLAGS_CF], 1, "CF after STC");
    run_step(exec_pkg::CMD_CLC, 32'd0, 32'd0, 32'd0, 4'd1, 1'b0);
    check_value(eflags[exec_pkg::EFLAGS_CF], 0, "CF after CLC");
    run_step(exec_pkg::CMD_STD, 32'd0, 32'd0, 32'd0, 4'd1, 1'b0);
    check_value(eflags[exec_pkg::EFLAGS_DF], 1, "DF after STD");
    run_step(exec_pkg::CMD_CLD, 32'd0, 32'd0, 32'd0, 4'd1, 1'b0);
    check_value(eflags[exec_pkg::EFLAGS_DF], 0, "DF after CLD");
    ah = take_bits(8);
    run_step(exec_pkg::CMD_SAHF, {16'd0, ah, 8'd0}, 32'd0, 32'd0, 4'd1, 1'b0);
    a = take_bits(32);
    run_step(exec_pkg::CMD_LAHF, a, 32'd0, 32'd0, 4'd1, 1'b0);
    // Bits 5 and 3 read as zero, bit 1 as one
    check_value(opnd0_w, {a[31:16], (ah & 8'hd5) | 8'h02, a[7:0]}, "LAHF result");
    end_test("flag ops", errs);

    errs = err_count;
    run_step(exec_pkg::CMD_CMP, 32'd9, 32'd9, 32'd0, 4'd2, 1'b0);
    check_branch(exec_pkg::CMD_JZ, 1'b0, 1'b1, "JZ with ZF set");
    check_branch(exec_pkg::CMD_JNZ, 1'b0, 1'b0, "JNZ with ZF set");
    check_branch(exec_pkg::CMD_JC, 1'b0, 1'b0, "JC with CF clear");
    run_step(exec_pkg::CMD_CMP, 32'd1, 32'd2, 32'd0, 4'd2, 1'b0);
    check_branch(exec_pkg::CMD_JZ, 1'b0, 1'b0, "JZ with ZF clear");
    check_branch(exec_pkg::CMD_JNZ, 1'b0, 1'b1, "JNZ with ZF clear");
    check_branch(exec_pkg::CMD_JC, 1'b0, 1'b1, "JC with CF set");
    check_branch(exec_pkg::CMD_JMP, 1'b0, 1'b1, "JMP target");
    check_branch(exec_pkg::CMD_CALL, 1'b0, 1'b1, "CALL target");
    check_branch(exec_pkg::CMD_RET, 1'b0, 1'b1, "RET address");
    check_branch(exec_pkg::CMD_LOOP, 1'b0, 1'b1, "LOOP with ECX nonzero");
    check_branch(exec_pkg::CMD_LOOP, 1'b1, 1'b0, "LOOP with ECX zero")
;
    end_test("control flow", errs);

    // Done falls back low once the steps stop
    errs = err_count;
    repeat (2) @(negedge clk);
    check_value(done, 0, "done while idle");
    end_test("idle", errs);

    $display("tests: %0d, errors: %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- exec_core_props.sv
`timescale 1ns/1ps

module exec_core_props (
  input logic        clk,
  input logic        rst_n,
  input logic        step_valid,
  input logic [6:0]  opc,
  input logic [31:0] opnd0_r,
  input logic [31:0] opnd1_r,
  input logic [3:0]  instr_len,
  input logic        done,
  input logic [31:0] opnd0_w,
  input logic [31:0] eflags,
  input logic [31:0] eip
);

  logic        is_ref_op;
  logic        is_jump;
  logic [32:0] ref_now;

  // Ops whose result and CF are modelled here
  assign is_ref_op = opc inside {exec_pkg::CMD_ADD, exec_pkg::CMD_SUB, exec_pkg::CMD_AND,
                                 exec_pkg::CMD_XOR, exec_pkg::CMD_SHL, exec_pkg::CMD_ROR};
  // Anything that may leave the sequential path
  assign is_jump = opc inside {exec_pkg::CMD_JMP, exec_pkg::CMD_JZ, exec_pkg::CMD_JNZ,
                               exec_pkg::CMD_JC, exec_pkg::CMD_CALL, exec_pkg::CMD_RET,
                               exec_pkg::CMD_LOOP};

  // Expected {CF, result}
  function automatic logic [32:0] ref_alu(input logic [6:0] op, input logic [31:0] a,
                                          input logic [31:0] b, input logic cf_old);
    logic [32:0] r;
    int          c;
    c = b[4:0];
    r = {cf_old, a};
    case (op)
      exec_pkg::CMD_ADD: r = {1'b0, a} + {1'b0, b};
      // Unsigned borrow when b is larger
      exec_pkg::CMD_SUB: r = {(a < b), a - b};
      exec_pkg::CMD_AND: r = {1'b0, a & b};
      exec_pkg::CMD_XOR: r = {1'b0, a ^ b};
      // Zero count keeps the old carry
      exec_pkg::CMD_SHL: if (c != 0) r = {a[32 - c], a << c};
      exec_pkg::CMD_ROR: if (c != 0) r = {a[c - 1], (a >> c) | (a << (32 - c))};
      default: r = {cf_old, a};
    endcase
    return r;
  endfunction

  // Reference for the step presented on the inputs now
  assign ref_now = ref_alu(opc, opnd0_r, opnd1_r, eflags[exec_pkg::EFLAGS_CF]);

  done_after_step: assert property (@(posedge clk) disable iff (!rst_n)
    step_valid |=> done)
    else begin
      $error("Error at %0t: no done after step", $time);
      tb_exec_core.err_count++;
    end

  no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
    !step_valid |=> !done)
    else begin
      $error("Error at %0t: done without step", $time);
      tb_exec_core.err_count++;
    end

  alu_result: assert property (@(posedge clk) disable iff (!rst_n)
    step_valid && is_ref_op |=> {eflags[exec_pkg::EFLAGS_CF], opnd0_w} == $past(ref_now))
    else begin
      $error("Error at %0t: ALU result or CF wrong", $time);
      tb_exec_core.err_count++;
    end

  // ZF and SF follow the reference result
  zf_sf_rule: assert property (@(posedge clk) disable iff (!rst_n)
    step_valid && is_ref_op |=>
      eflags[exec_pkg::EFLAGS_ZF] == ($past(ref_now[31:0]) == 32'd0) &&
      eflags[exec_pkg::EFLAGS_SF] == $past(ref_now[31]))
    else begin
      $error("Error at %0t: ZF or SF wrong", $time);
      tb_exec_core.err_count++;
    end

  seq_eip: assert property (@(posedge clk) disable iff (!rst_n)
    step_valid && !is_jump |=> eip == $past(eip) + $past(instr_len))
    else begin
      $error("Error at %0t: EIP not sequential", $time);
      tb_exec_core.err_count++;
    end

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        step_valid,
  input  logic [6:0]  opc,
  input  logic [31:0] opnd0_r,
  input  logic [31:0] opnd1_r,
  input  logic [31:0] opnd2_r,
  input  logic [3:0]  instr_len,
  input  logic        ecx_is_zero,
  output logic        done,
  output logic [31:0] opnd0_w,
  output logic [31:0] opnd1_w,
  output logic [31:0] eflags,
  output logic [31:0] eip
);

  exec_pkg::eflags_t eflags_q;
  exec_pkg::eflags_t nxt_eflags;
  logic [31:0]       nxt_eip;
  logic [31:0]       exe_opnd0_w;
  logic [31:0]       exe_opnd1_w;

  // Whole step is combinational from the current state
  execute execute_i (
    .opc         (opc),
    .eflags      (eflags_q),
    .ecx_is_zero (ecx_is_zero),
    .eip         (eip),
    .instr_len   (instr_len),
    .opnd0_r     (opnd0_r),
    .opnd1_r     (opnd1_r),
    .opnd2_r     (opnd2_r),
    .next_eflags (nxt_eflags),
    .next_eip    (nxt_eip),
    .opnd0_w     (exe_opnd0_w),
    .opnd1_w     (exe_opnd1_w)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done         <= 1'b0;
      eflags_q.raw <= exec_pkg::EFLAGS_RESET;
      eip          <= 32'd0;
      opnd0_w      <= 32'd0;
      opnd1_w      <= 32'd0;
    end else begin
      // One-cycle pulse per accepted step
      done <= step_valid;
      // State and results only move on a step
      if (step_valid) begin
        eflags_q <= nxt_eflags;
        eip      <= nxt_eip;
        opnd0_w  <= exe_opnd0_w;
        opnd1_w  <= exe_opnd1_w;
      end
    end
  end

  assign eflags = eflags_q.raw;

endmodule

//--- execute.sv
`timescale 1ns/1ps

module execute (
  input  logic [6:0]        opc,
  input  exec_pkg::eflags_t eflags,
  input  logic              ecx_is_zero,
  input  logic [31:0]       eip,
  input  logic [3:0]        instr_len,
  input  logic [31:0]       opnd0_r,
  input  logic [31:0]       opnd1_r,
  input  logic [31:0]       opnd2_r,
  output exec_pkg::eflags_t next_eflags,
  output logic [31:0]       next_eip,
  output logic [31:0]       opnd0_w,
  output logic [31:0]       opnd1_w
);

  logic [127:0]                    opc_1hot;
  logic                            is_adjust;
  logic                            op_add;
  logic                            op_sub;
  logic                            op_and;
  logic                            op_or;
  logic                            op_xor;
  logic                            op_shift;
  logic                            exe_is_alu;
  logic                            exe_is_mu;
  logic                            exe_is_meta;
  logic                            alu_no_wr;
  logic                            alu_no_flags;
  logic [exec_pkg::ALU_CNTL_W-1:0] alu_cntl;
  logic [31:0]                     alu_a;
  logic [31:0]                     alu_b;
  logic [31:0]                     alu_result;
  logic                            alu_cf;
  logic                            alu_pf;
  logic                            alu_af;
  logic                            alu_zf;
  logic                            alu_sf;
  logic                            alu_of;
  exec_pkg::eflags_t               alu_eflags;
  logic [31:0]                     mu_opnd0_w;
  logic [31:0]                     mu_opnd1_w;
  logic                            ah_wr;
  logic [31:0]                     meta_result;
  exec_pkg::eflags_t               meta_eflags;

  assign opc_1hot = 128'd1 << opc;

  // Stack pointer and ECX updates borrow the adder
  assign is_adjust = opc_1hot[exec_pkg::CMD_PUSH] | opc_1hot[exec_pkg::CMD_POP] |
                     opc_1hot[exec_pkg::CMD_CALL] | opc_1hot[exec_pkg::CMD_RET] |
                     opc_1hot[exec_pkg::CMD_LOOP];

  // POP and RET add, PUSH, CALL and LOOP subtract
  assign op_add = opc_1hot[exec_pkg::CMD_ADD] | opc_1hot[exec_pkg::CMD_ADC] |
                  opc_1hot[exec_pkg::CMD_INC] | opc_1hot[exec_pkg::CMD_POP] |
                  opc_1hot[exec_pkg::CMD_RET];
  assign op_sub = opc_1hot[exec_pkg::CMD_SUB] | opc_1hot[exec_pkg::CMD_SBB] |
                  opc_1hot[exec_pkg::CMD_DEC] | opc_1hot[exec_pkg::CMD_CMP] |
                  opc_1hot[exec_pkg::CMD_PUSH] | opc_1hot[exec_pkg::CMD_CALL] |
                  opc_1hot[exec_pkg::CMD_LOOP];
  assign op_and = opc_1hot[exec_pkg::CMD_AND] | opc_1hot[exec_pkg::CMD_TEST];
  assign op_or  = opc_1hot[exec_pkg::CMD_OR];
  // NOT is XOR against all ones
  assign op_xor = opc_1hot[exec_pkg::CMD_XOR] | opc_1hot[exec_pkg::CMD_NOT];
  assign op_shift = opc_1hot[exec_pkg::CMD_SHL] | opc_1hot[exec_pkg::CMD_SHR] |
                    opc_1hot[exec_pkg::CMD_ROL] | opc_1hot[exec_pkg::CMD_ROR];

  assign exe_is_alu = op_add | op_sub | op_and | op_or | op_xor | op_shift;

  // Compares only set flags
  assign alu_no_wr = opc_1hot[exec_pkg::CMD_CMP] | opc_1hot[exec_pkg::CMD_TEST];
  // NOT and the adjustments leave EFLAGS alone
  assign alu_no_flags = opc_1hot[exec_pkg::CMD_NOT] | is_adjust;

  always_comb begin
    alu_cntl = '0;
    alu_cntl[exec_pkg::ALU_C_ADD]     = op_add;
    alu_cntl[exec_pkg::ALU_C_SUB]     = op_sub;
    alu_cntl[exec_pkg::ALU_C_AND]     = op_and;
    alu_cntl[exec_pkg::ALU_C_OR]      = op_or;
    alu_cntl[exec_pkg::ALU_C_XOR]     = op_xor;
    alu_cntl[exec_pkg::ALU_C_SHL]     = opc_1hot[exec_pkg::CMD_SHL];
    alu_cntl[exec_pkg::ALU_C_SHR]     = opc_1hot[exec_pkg::CMD_SHR];
    alu_cntl[exec_pkg::ALU_C_ROL]     = opc_1hot[exec_pkg::CMD_ROL];
    alu_cntl[exec_pkg::ALU_C_ROR]     = opc_1hot[exec_pkg::CMD_ROR];
    alu_cntl[exec_pkg::ALU_C_SRC_INV] = op_sub;
    // SBB gets its carry-in from CF instead
    alu_cntl[exec_pkg::ALU_C_SRC_INC] = op_sub & ~opc_1hot[exec_pkg::CMD_SBB];
    alu_cntl[exec_pkg::ALU_C_USE_CARRY] = opc_1hot[exec_pkg::CMD_ADC] |
                                          opc_1hot[exec_pkg::CMD_SBB];
    alu_cntl[exec_pkg::ALU_C_CLEAR_CF_OF] = op_and | opc_1hot[exec_pkg::CMD_OR] |
                                            opc_1hot[exec_pkg::CMD_XOR];
    alu_cntl[exec_pkg::ALU_C_KEEP_CF] = opc_1hot[exec_pkg::CMD_INC] |
                                        opc_1hot[exec_pkg::CMD_DEC];
  end

  // Adjustments shift the operands down by one slot
  assign alu_a = is_adjust ? opnd1_r : opnd0_r;
  assign alu_b = is_adjust                      ? opnd2_r :
                 alu_cntl[exec_pkg::ALU_C_KEEP_CF] ? 32'd1 :
                 opc_1hot[exec_pkg::CMD_NOT]       ? 32'hffff_ffff :
                 opnd1_r;

  alu alu_i (
    .cntl    (alu_cntl),
    .cf_in   (eflags.f.cf),
    .af_in   (eflags.f.af),
    .opnd0_r (alu_a),
    .opnd1_r (alu_b),
    .result  (alu_result),
    .cf      (alu_cf),
    .pf      (alu_pf),
    .af      (alu_af),
    .zf      (alu_zf),
    .sf      (alu_sf),
    .of      (alu_of)
  );

  // Status flags merged into the current EFLAGS
  always_comb begin
    alu_eflags      = eflags;
    alu_eflags.f.of = alu_of;
    alu_eflags.f.sf = alu_sf;
    alu_eflags.f.zf = alu_zf;
    alu_eflags.f.af = alu_af;
    alu_eflags.f.pf = alu_pf;
    alu_eflags.f.cf = alu_cf;
  end

  // LEA arrives with the address already in opnd1_r, so it is a plain move
  assign exe_is_mu = opc_1hot[exec_pkg::CMD_MOV]   | opc_1hot[exec_pkg::CMD_LEA] |
                     opc_1hot[exec_pkg::CMD_MOVSX] | opc_1hot[exec_pkg::CMD_MOVZX] |
                     opc_1hot[exec_pkg::CMD_XCHG];

  assign mu_opnd0_w = opc_1hot[exec_pkg::CMD_MOVSX] ? {{24{opnd1_r[7]}}, opnd1_r[7:0]} :
                      opc_1hot[exec_pkg::CMD_MOVZX] ? {24'd0, opnd1_r[7:0]} :
                      opnd1_r;
  // Only XCHG writes the second operand
  assign mu_opnd1_w = opc_1hot[exec_pkg::CMD_XCHG] ? opnd0_r : opnd1_r;

  assign exe_is_meta = opc_1hot[exec_pkg::CMD_STC] | opc_1hot[exec_pkg::CMD_CLC] |
                       opc_1hot[exec_pkg::CMD_STD] | opc_1hot[exec_pkg::CMD_CLD] |
                       opc_1hot[exec_pkg::CMD_LAHF] | opc_1hot[exec_pkg::CMD_SAHF];

  // EAX comes in on opnd0
  meta_unit meta_i (
    .opc       (opc),
    .flags_in  (eflags),
    .opnd_in   (opnd0_r),
    .ah_wr     (ah_wr),
    .result    (meta_result),
    .flags_out (meta_eflags)
  );

  // Every step moves EIP somewhere
  cfu cfu_i (
    .opc         (opc),
    .flags       (eflags),
    .ecx_is_zero (ecx_is_zero),
    .eip         (eip),
    .instr_len   (instr_len),
    .target      (opnd0_r),
    .ret_addr    (opnd2_r),
    .next_eip    (next_eip)
  );

  // Write operand 0: LAHF, then ALU, then moves, otherwise untouched
  assign opnd0_w = ah_wr                                      ? meta_result :
                   (exe_is_alu && !alu_no_wr && !is_adjust) ? alu_result  :
                   exe_is_mu                                  ? mu_opnd0_w  :
                   opnd0_r;

  // Write operand 1 carries the adjusted ESP or ECX
  assign opnd1_w = exe_is_mu ? mu_opnd1_w :
                   is_adjust ? alu_result :
                   opnd1_r;

  assign next_eflags = (exe_is_alu && !alu_no_flags) ? alu_eflags  :
                       exe_is_meta                    ? meta_eflags :
                       eflags;

endmodule

//--- cfu.sv
`timescale 1ns/1ps

module cfu (
  input  logic [6:0]        opc,
  input  exec_pkg::eflags_t flags,
  input  logic              ecx_is_zero,
  input  logic [31:0]       eip,
  input  logic [3:0]        instr_len,
  input  logic [31:0]       target,
  input  logic [31:0]       ret_addr,
  output logic [31:0]       next_eip
);

  logic [31:0] seq_eip;

  // Fall-through address
  assign seq_eip = eip + {28'd0, instr_len};

  always_comb begin
    case (opc)
      // Unconditional transfers
      exec_pkg::CMD_JMP,
      exec_pkg::CMD_CALL: next_eip = target;
      exec_pkg::CMD_RET:  next_eip = ret_addr;
      // Conditional branches test the flags from the last step
      exec_pkg::CMD_JZ:   next_eip = flags.f.zf ? target : seq_eip;
      exec_pkg::CMD_JNZ:  next_eip = flags.f.zf ? seq_eip : target;
      exec_pkg::CMD_JC:   next_eip = flags.f.cf ? target : seq_eip;
      // ECX comes in already decremented
      exec_pkg::CMD_LOOP: next_eip = ecx_is_zero ? seq_eip : target;
      default:            next_eip = seq_eip;
    endcase
  end

endmodule

//--- meta_unit.sv
`timescale 1ns/1ps

module meta_unit (
  input  logic [6:0]       opc,
  input  exec_pkg::eflags_t flags_in,
  input  logic [31:0]      opnd_in,
  output logic             ah_wr,
  output logic [31:0]      result,
  output exec_pkg::eflags_t flags_out
);

  always_comb begin
    // Everything passes through unless the opcode says otherwise
    flags_out = flags_in;
    result    = opnd_in;
    ah_wr     = 1'b0;
    case (opc)
      exec_pkg::CMD_STC: flags_out.f.cf = 1'b1;
      exec_pkg::CMD_CLC: flags_out.f.cf = 1'b0;
      exec_pkg::CMD_STD: flags_out.f.df = 1'b1;
      exec_pkg::CMD_CLD: flags_out.f.df = 1'b0;
      exec_pkg::CMD_LAHF: begin
        // AH gets SF:ZF:0:AF:0:PF:1:CF
        result[15:8] = {flags_in.f.sf, flags_in.f.zf, 1'b0, flags_in.f.af,
                        1'b0, flags_in.f.pf, 1'b1, flags_in.f.cf};
        ah_wr = 1'b1;
      end
      exec_pkg::CMD_SAHF: begin
        // AH bits sit at the same offsets as the low EFLAGS byte
        flags_out.f.sf = opnd_in[8 + exec_pkg::EFLAGS_SF];
        flags_out.f.zf = opnd_in[8 + exec_pkg::EFLAGS_ZF];
        flags_out.f.af = opnd_in[8 + exec_pkg::EFLAGS_AF];
        flags_out.f.pf = opnd_in[8 + exec_pkg::EFLAGS_PF];
        flags_out.f.cf = opnd_in[8 + exec_pkg::EFLAGS_CF];
      end
      default: begin
        // Not a flag op, outputs stay as passed through
        ah_wr = 1'b0;
      end
    endcase
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [exec_pkg::ALU_CNTL_W-1:0] cntl,
  input  logic                            cf_in,
  input  logic                            af_in,
  input  logic [31:0]                     opnd0_r,
  input  logic [31:0]                     opnd1_r,
  output logic [31:0]                     result,
  output logic                            cf,
  output logic                            pf,
  output logic                            af,
  output logic                            zf,
  output logic                            sf,
  output logic                            of
);

  logic [31:0] src_b;
  logic        carry_in;
  logic [32:0] sum;
  logic [4:0]  cnt;
  logic [32:0] shl_ext;
  logic [32:0] shr_ext;
  logic [63:0] rol_ext;
  logic [63:0] ror_ext;
  logic        arith;
  logic        cf_raw;
  logic        of_raw;

  // Subtract runs through the adder as a + ~b + 1
  assign src_b = cntl[exec_pkg::ALU_C_SRC_INV] ? ~opnd1_r : opnd1_r;

  // SBB takes the inverted borrow as carry-in, ADC the plain carry
  assign carry_in = cntl[exec_pkg::ALU_C_USE_CARRY] ?
                    (cf_in ^ cntl[exec_pkg::ALU_C_SRC_INV]) :
                    cntl[exec_pkg::ALU_C_SRC_INC];

  assign sum = {1'b0, opnd0_r} + {1'b0, src_b} + {32'd0, carry_in};

  // Shift count, low five bits only
  assign cnt = opnd1_r[4:0];

  // Extra bit on each side catches the last bit shifted out
  assign shl_ext = {1'b0, opnd0_r} << cnt;
  assign shr_ext = {opnd0_r, 1'b0} >> cnt;

  // Doubled word turns a shift into a rotate
  assign rol_ext = {opnd0_r, opnd0_r} << cnt;
  assign ror_ext = {opnd0_r, opnd0_r} >> cnt;

  assign arith = cntl[exec_pkg::ALU_C_ADD] | cntl[exec_pkg::ALU_C_SUB];

  always_comb begin
    // Adder result by default
    result = sum[31:0];
    // Carry out, or borrow when subtracting
    cf_raw = sum[32] ^ cntl[exec_pkg::ALU_C_SRC_INV];
    // Same-sign inputs giving a different-sign sum
    of_raw = (opnd0_r[31] == src_b[31]) && (sum[31] != opnd0_r[31]);
    if (cntl[exec_pkg::ALU_C_AND]) begin
      result = opnd0_r & opnd1_r;
    end else if (cntl[exec_pkg::ALU_C_OR]) begin
      result = opnd0_r | opnd1_r;
    end else if (cntl[exec_pkg::ALU_C_XOR]) begin
      result = opnd0_r ^ opnd1_r;
    end else if (cntl[exec_pkg::ALU_C_SHL]) begin
      result = shl_ext[31:0];
      // Zero count leaves the carry alone
      cf_raw = (cnt == 5'd0) ? cf_in : shl_ext[32];
      of_raw = shl_ext[31] ^ shl_ext[32];
    end else if (cntl[exec_pkg::ALU_C_SHR]) begin
      result = shr_ext[32:1];
      cf_raw = (cnt == 5'd0) ? cf_in : shr_ext[0];
      of_raw = opnd0_r[31];
    end else if (cntl[exec_pkg::ALU_C_ROL]) begin
      result = rol_ext[63:32];
      // Bit rotated into the LSB
      cf_raw = (cnt == 5'd0) ? cf_in : rol_ext[32];
      of_raw = rol_ext[63] ^ rol_ext[32];
    end else if (cntl[exec_pkg::ALU_C_ROR]) begin
      result = ror_ext[31:0];
      // Bit rotated into the MSB
      cf_raw = (cnt == 5'd0) ? cf_in : ror_ext[31];
      of_raw = ror_ext[31] ^ ror_ext[30];
    end
  end

  assign zf = (result == 32'd0);
  assign sf = result[31];
  // Even parity of the low byte
  assign pf = ~^result[7:0];

  // Carry into bit 4, inverted to a borrow for subtract
  // Non-arithmetic ops keep the old AF
  assign af = arith ? (opnd0_r[4] ^ src_b[4] ^ sum[4] ^ cntl[exec_pkg::ALU_C_SRC_INV]) :
              af_in;

  // INC and DEC never touch CF, logic ops clear it
  assign cf = cntl[exec_pkg::ALU_C_KEEP_CF]     ? cf_in :
              cntl[exec_pkg::ALU_C_CLEAR_CF_OF] ? 1'b0  :
              cf_raw;
  assign of = cntl[exec_pkg::ALU_C_CLEAR_CF_OF] ? 1'b0 : of_raw;

endmodule

//--- exec_pkg.sv
package exec_pkg;

  // Opcode encodings, 7 bits to match the decoder output
  // Zero is reserved for NOP so an idle opcode bus is harmless
  localparam logic [6:0] CMD_NOP   = 7'd0;

  // Arithmetic
  localparam logic [6:0] CMD_ADD   = 7'd1;
  localparam logic [6:0] CMD_ADC   = 7'd2;
  localparam logic [6:0] CMD_INC   = 7'd3;
  localparam logic [6:0] CMD_SUB   = 7'd4;
  localparam logic [6:0] CMD_SBB   = 7'd5;
  localparam logic [6:0] CMD_DEC   = 7'd6;
  localparam logic [6:0] CMD_CMP   = 7'd7;

  // Logic, shift and rotate
  localparam logic [6:0] CMD_AND   = 7'd8;
  localparam logic [6:0] CMD_TEST  = 7'd9;
  localparam logic [6:0] CMD_OR    = 7'd10;
  localparam logic [6:0] CMD_XOR   = 7'd11;
  localparam logic [6:0] CMD_NOT   = 7'd12;
  localparam logic [6:0] CMD_SHL   = 7'd13;
  localparam logic [6:0] CMD_SHR   = 7'd14;
  localparam logic [6:0] CMD_ROL   = 7'd15;
  localparam logic [6:0] CMD_ROR   = 7'd16;

  // Stack and ECX adjustments, done by the ALU on opnd1/opnd2
  localparam logic [6:0] CMD_PUSH  = 7'd17;
  localparam logic [6:0] CMD_POP   = 7'd18;
  localparam logic [6:0] CMD_CALL  = 7'd19;
  localparam logic [6:0] CMD_RET   = 7'd20;
  localparam logic [6:0] CMD_LOOP  = 7'd21;

  // Moves
  localparam logic [6:0] CMD_MOV   = 7'd22;
  localparam logic [6:0] CMD_MOVSX = 7'd23;
  localparam logic [6:0] CMD_MOVZX = 7'd24;
  localparam logic [6:0] CMD_LEA   = 7'd25;
  localparam logic [6:0] CMD_XCHG  = 7'd26;

  // Flag manipulation
  localparam logic [6:0] CMD_STC   = 7'd27;
  localparam logic [6:0] CMD_CLC   = 7'd28;
  localparam logic [6:0] CMD_STD   = 7'd29;
  localparam logic [6:0] CMD_CLD   = 7'd30;
  localparam logic [6:0] CMD_LAHF  = 7'd31;
  localparam logic [6:0] CMD_SAHF  = 7'd32;

  // Branches
  localparam logic [6:0] CMD_JMP   = 7'd33;
  localparam logic [6:0] CMD_JZ    = 7'd34;
  localparam logic [6:0] CMD_JNZ   = 7'd35;
  localparam logic [6:0] CMD_JC    = 7'd36;

  // EFLAGS bit positions
  localparam logic [4:0] EFLAGS_CF = 5'd0;
  localparam logic [4:0] EFLAGS_PF = 5'd2;
  localparam logic [4:0] EFLAGS_AF = 5'd4;
  localparam logic [4:0] EFLAGS_ZF = 5'd6;
  localparam logic [4:0] EFLAGS_SF = 5'd7;
  localparam logic [4:0] EFLAGS_DF = 5'd10;
  localparam logic [4:0] EFLAGS_OF = 5'd11;

  // Bit 1 always reads as one
  localparam logic [31:0] EFLAGS_RESET = 32'h2;

  // ALU control word layout
  localparam int ALU_CNTL_W        = 14;
  localparam int ALU_C_ADD         = 0;
  localparam int ALU_C_SUB         = 1;
  localparam int ALU_C_AND         = 2;
  localparam int ALU_C_OR          = 3;
  localparam int ALU_C_XOR         = 4;
  localparam int ALU_C_SHL         = 5;
  localparam int ALU_C_SHR         = 6;
  localparam int ALU_C_ROL         = 7;
  localparam int ALU_C_ROR         = 8;
  localparam int ALU_C_SRC_INV     = 9;
  localparam int ALU_C_SRC_INC     = 10;
  localparam int ALU_C_USE_CARRY   = 11;
  localparam int ALU_C_CLEAR_CF_OF = 12;
  localparam int ALU_C_KEEP_CF     = 13;

  // Field view of EFLAGS, low byte laid out as in LAHF/SAHF
  typedef struct packed {
    logic [19:0] rsvd;
    logic        of;
    logic        df;
    logic        if_;
    logic        tf;
    logic        sf;
    logic        zf;
    logic        r5;
    logic        af;
    logic        r3;
    logic        pf;
    logic        r1;
    logic        cf;
  } eflags_bits_t;

  // Same 32 bits seen as a word or as named flags
  typedef union packed {
    logic [31:0]  raw;
    eflags_bits_t f;
  } eflags_t;

endpackage
